// File: Makefile
VERILATOR ?= verilator
TOP       ?= fxp_gain_clamp_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
+incdir+src
src/fxp_pkg.sv
src/axis_if.sv
src/axis_skid_buffer.sv
src/axis_gain.sv
src/axis_clamp.sv
src/fxp_gain_clamp.sv
tests/fxp_gain_clamp_sva.sv
tests/fxp_gain_clamp_tb.sv

// File: src/axis_clamp.sv
`include "fxp_consts.svh"

module axis_clamp (
  input  logic             clk,
  input  logic             arst_n_i,
  axis_if.sink             s,
  output fxp_pkg::sample_t m_data_o,
  output logic             m_last_o,
  output logic             m_user_o,
  output logic             m_valid_o,
  input  logic             m_ready_i
);

  // Q8.8 result plus last and user
  localparam int PAYLOAD_W = `FXP_OUT_W + 2;

  fxp_pkg::prod_u           word;
  logic [`FXP_GUARD_W:0]    sign_bits;
  logic                     sign;
  logic                     overflow;
  logic [`FXP_OUT_W-1:0]    result;
  logic [PAYLOAD_W-1:0]     in_payload;
  logic [PAYLOAD_W-1:0]     out_payload;

  assign word = s.data;
  assign sign = word.raw[`FXP_PROD_W-1];

  // guard bits and the kept sign must all agree to fit in Q8.8
  assign sign_bits = {word.fields.guard, word.fields.kept[`FXP_OUT_W-1]};
  assign overflow  = !(&sign_bits) && (|sign_bits);

  // saturate toward the true sign, else plain truncation (floor)
  always_comb begin
    if (overflow) begin
      result = {sign, {(`FXP_OUT_W-1){~sign}}};
    end else begin
      result = word.fields.kept;
    end
  end

  // saturation is flagged on the user bit
  assign in_payload = {result, s.last, s.user | overflow};

  axis_skid_buffer #(
    .WIDTH(PAYLOAD_W)
  ) u_skid (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .s_payload_i(in_payload),
    .s_valid_i  (s.valid),
    .s_ready_o  (s.ready),
    .m_payload_o(out_payload),
    .m_valid_o  (m_valid_o),
    .m_ready_i  (m_ready_i)
  );

  assign m_data_o = out_payload[PAYLOAD_W-1:2];
  assign m_last_o = out_payload[1];
  assign m_user_o = out_payload[0];

endmodule

// File: src/axis_gain.sv
`include "fxp_consts.svh"

module axis_gain (
  input  logic             clk,
  input  logic             arst_n_i,
  input  fxp_pkg::gain_t   gain_i,
  input  fxp_pkg::sample_t s_data_i,
  input  logic             s_last_i,
  input  logic             s_user_i,
  input  logic             s_valid_i,
  output logic             s_ready_o,
  axis_if.source           m
);

  // product plus last and user
  localparam int PAYLOAD_W = `FXP_PROD_W + 2;

  fxp_pkg::prod_t         prod;
  logic [PAYLOAD_W-1:0]   in_payload;
  logic [PAYLOAD_W-1:0]   out_payload;

  // exact Q8.8 x Q4.12, both operands sign extended first
  assign prod = fxp_pkg::prod_t'(s_data_i) * fxp_pkg::prod_t'(gain_i);

  // gain is taken as it stands when the sample is accepted
  assign in_payload = {prod, s_last_i, s_user_i};

  axis_skid_buffer #(
    .WIDTH(PAYLOAD_W)
  ) u_skid (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .s_payload_i(in_payload),
    .s_valid_i  (s_valid_i),
    .s_ready_o  (s_ready_o),
    .m_payload_o(out_payload),
    .m_valid_o  (m.valid),
    .m_ready_i  (m.ready)
  );

  // unpack toward the clamp stage
  assign m.data = out_payload[PAYLOAD_W-1:2];
  assign m.last = out_payload[1];
  assign m.user = out_payload[0];

endmodule

// File: src/axis_if.sv
`include "fxp_consts.svh"

// valid/ready stream link with last and a single user bit
interface axis_if #(
  parameter int DATA_W = `FXP_PROD_W
);

  logic [DATA_W-1:0] data;
  logic              last;
  logic              user;
  logic              valid;
  logic              ready;

  modport source (
    output data,
    output last,
    output user,
    output valid,
    input  ready
  );

  modport sink (
    input  data,
    input  last,
    input  user,
    input  valid,
    output ready
  );

endinterface

// File: src/axis_skid_buffer.sv
module axis_skid_buffer #(
  parameter int WIDTH = 34
) (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic [WIDTH-1:0] s_payload_i,
  input  logic             s_valid_i,
  output logic             s_ready_o,
  output logic [WIDTH-1:0] m_payload_o,
  output logic             m_valid_o,
  input  logic             m_ready_i
);

  logic             ready_q;
  logic             ready_early;

  logic [WIDTH-1:0] out_payload_q;
  logic             out_valid_q;
  logic             out_valid_d;

  logic [WIDTH-1:0] tmp_payload_q;
  logic             tmp_valid_q;
  logic             tmp_valid_d;

  logic             load_out_from_in;
  logic             load_tmp_from_in;
  logic             load_out_from_tmp;

  assign s_ready_o   = ready_q;
  assign m_payload_o = out_payload_q;
  assign m_valid_o   = out_valid_q;

  // ready next cycle unless the skid entry could fill up now
  assign ready_early = m_ready_i || (!tmp_valid_q && (!out_valid_q || !s_valid_i));

  always_comb begin
    out_valid_d       = out_valid_q;
    tmp_valid_d       = tmp_valid_q;
    load_out_from_in  = 1'b0;
    load_tmp_from_in  = 1'b0;
    load_out_from_tmp = 1'b0;

    if (ready_q) begin
      if (m_ready_i || !out_valid_q) begin
        // output slot is free or draining, go straight through
        out_valid_d      = s_valid_i;
        load_out_from_in = 1'b1;
      end else begin
        // output stalled, park the beat in the skid entry
        tmp_valid_d      = s_valid_i;
        load_tmp_from_in = 1'b1;
      end
    end else if (m_ready_i) begin
      // input closed, refill output from the skid entry
      out_valid_d       = tmp_valid_q;
      tmp_valid_d       = 1'b0;
      load_out_from_tmp = 1'b1;
    end
  end

  // control state
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q     <= 1'b0;
      out_valid_q <= 1'b0;
      tmp_valid_q <= 1'b0;
    end else begin
      ready_q     <= ready_early;
      out_valid_q <= out_valid_d;
      tmp_valid_q <= tmp_valid_d;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (load_out_from_in) begin
      out_payload_q <= s_payload_i;
    end else if (load_out_from_tmp) begin
      out_payload_q <= tmp_payload_q;
    end

    if (load_tmp_from_in) begin
      tmp_payload_q <= s_payload_i;
    end
  end

endmodule

// File: src/fxp_consts.svh
`ifndef FXP_CONSTS_SVH
`define FXP_CONSTS_SVH

// input sample, signed Q8.8
`define FXP_IN_W 16
`define FXP_IN_FRAC 8

// gain, signed Q4.12
`define FXP_GAIN_W 16
`define FXP_GAIN_FRAC 12

// output sample, signed Q8.8
`define FXP_OUT_W 16
`define FXP_OUT_FRAC 8

// full precision product, signed Q12.20
`define FXP_PROD_W (`FXP_IN_W + `FXP_GAIN_W)

// fraction bits lost when going back to the output format
`define FXP_DROP_W (`FXP_IN_FRAC + `FXP_GAIN_FRAC - `FXP_OUT_FRAC)

// integer bits above the kept window, checked for overflow
`define FXP_GUARD_W (`FXP_PROD_W - `FXP_OUT_W - `FXP_DROP_W)

`endif

// File: src/fxp_gain_clamp.sv
`include "fxp_consts.svh"

module fxp_gain_clamp (
  input  logic             clk,
  input  logic             arst_n_i,

  // gain, held steady while beats are in flight
  input  fxp_pkg::gain_t   gain_i,

  // sample input stream
  input  fxp_pkg::sample_t s_data_i,
  input  logic             s_last_i,
  input  logic             s_user_i,
  input  logic             s_valid_i,
  output logic             s_ready_o,

  // result output stream
  output fxp_pkg::sample_t m_data_o,
  output logic             m_last_o,
  output logic             m_user_o,
  output logic             m_valid_o,
  input  logic             m_ready_i
);

  // product link between the two stages
  axis_if #(
    .DATA_W(`FXP_PROD_W)
  ) prod_if ();

  axis_gain u_gain (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .gain_i   (gain_i),
    .s_data_i (s_data_i),
    .s_last_i (s_last_i),
    .s_user_i (s_user_i),
    .s_valid_i(s_valid_i),
    .s_ready_o(s_ready_o),
    .m        (prod_if.source)
  );

  axis_clamp u_clamp (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .s        (prod_if.sink),
    .m_data_o (m_data_o),
    .m_last_o (m_last_o),
    .m_user_o (m_user_o),
    .m_valid_o(m_valid_o),
    .m_ready_i(m_ready_i)
  );

endmodule

// File: src/fxp_pkg.sv
`include "fxp_consts.svh"

package fxp_pkg;

  // signed Q8.8 sample, used on both ends of the pipeline
  typedef logic signed [`FXP_IN_W-1:0] sample_t;

  // signed Q4.12 gain
  typedef logic signed [`FXP_GAIN_W-1:0] gain_t;

  // signed Q12.20 product
  typedef logic signed [`FXP_PROD_W-1:0] prod_t;

  // product split around the Q8.8 window
  typedef struct packed {
    logic [`FXP_GUARD_W-1:0] guard;
    logic [`FXP_OUT_W-1:0]   kept;
    logic [`FXP_DROP_W-1:0]  dropped;
  } prod_fields_t;

  // same product word, read whole or by field
  typedef union packed {
    prod_t        raw;
    prod_fields_t fields;
  } prod_u;

endpackage

// File: tests/fxp_gain_clamp_sva.sv
`include "fxp_consts.svh"

module fxp_gain_clamp_sva (
  input logic                  clk,
  input logic                  arst_n_i,
  input logic                  s_ready_o,
  input logic [`FXP_OUT_W-1:0] m_data_o,
  input logic                  m_last_o,
  input logic                  m_user_o,
  input logic                  m_valid_o,
  input logic                  m_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // output beat must hold until the sink takes it
  property hold_while_stalled;
    @(posedge clk) disable iff (!arst_n_i)
      (m_valid_o && !m_ready_i) |=>
        (m_valid_o && $stable(m_data_o) && $stable(m_last_o) && $stable(m_user_o));
  endproperty

  property no_valid_in_reset;
    @(posedge clk) !arst_n_i |-> !m_valid_o;
  endproperty

  property no_ready_in_reset;
    @(posedge clk) !arst_n_i |-> !s_ready_o;
  endproperty

  a_hold_while_stalled: assert property (hold_while_stalled)
    else $error("output beat changed while the sink was stalled");

  a_no_valid_in_reset: assert property (no_valid_in_reset)
    else $error("m_valid_o high during reset");

  a_no_ready_in_reset: assert property (no_ready_in_reset)
    else $error("s_ready_o high during reset");

endmodule

bind fxp_gain_clamp fxp_gain_clamp_sva u_sva (
  .clk      (clk),
  .arst_n_i (arst_n_i),
  .s_ready_o(s_ready_o),
  .m_data_o (m_data_o),
  .m_last_o (m_last_o),
  .m_user_o (m_user_o),
  .m_valid_o(m_valid_o),
  .m_ready_i(m_ready_i)
);

// File: tests/fxp_gain_clamp_tb.sv
`include "fxp_consts.svh"

module fxp_gain_clamp_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  localparam int DROP_BITS  = `FXP_IN_FRAC + `FXP_GAIN_FRAC - `FXP_OUT_FRAC;
  localparam longint OUT_MAX = (longint'(1) <<< (`FXP_OUT_W - 1)) - 1;
  localparam longint OUT_MIN = -(longint'(1) <<< (`FXP_OUT_W - 1));

  // beats per test sizing the watchdog
  localparam int UNITY_BEATS     = 8;
  localparam int SAT_BEATS       = 6;
  localparam int TRUNC_BEATS     = 4;
  localparam int RAND_BLOCKS     = 8;
  localparam int RAND_PER_BLOCK  = 20;
  localparam int BP_BEATS        = 10;
  localparam int NUM_BEATS       = UNITY_BEATS + SAT_BEATS + TRUNC_BEATS
                                 + RAND_BLOCKS * RAND_PER_BLOCK + BP_BEATS;
  localparam int WATCHDOG_CYCLES = NUM_BEATS * 20 + 200;

  localparam int READY_HIGH   = 0;
  localparam int READY_LOW    = 1;
  localparam int READY_RANDOM = 2;

  logic             clk;
  logic             arst_n_i;
  fxp_pkg::gain_t   gain_i;
  fxp_pkg::sample_t s_data_i;
  logic             s_last_i;
  logic             s_user_i;
  logic             s_valid_i;
  logic             s_ready_o;
  fxp_pkg::sample_t m_data_o;
  logic             m_last_o;
  logic             m_user_o;
  logic             m_valid_o;
  logic             m_ready_i;

  int seed = 63201;
  int ready_mode = READY_HIGH;
  int cycle_count = 0;
  int in_count = 0;
  int out_count = 0;
  int sat_count = 0;
  bit check_latency = 1'b0;

  // expected {data, last, user} and acceptance cycle per beat
  logic [17:0] exp_q[$];
  int          cyc_q[$];

  fxp_gain_clamp DUT (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .gain_i   (gain_i),
    .s_data_i (s_data_i),
    .s_last_i (s_last_i),
    .s_user_i (s_user_i),
    .s_valid_i(s_valid_i),
    .s_ready_o(s_ready_o),
    .m_data_o (m_data_o),
    .m_last_o (m_last_o),
    .m_user_o (m_user_o),
    .m_valid_o(m_valid_o),
    .m_ready_i(m_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                  name, got, expected));
    end
  endtask

  // expected {data, user} for Q8.8 times Q4.12
  // floored back to Q8.8 and saturated when out of range
  function automatic logic [16:0] expected_result(input logic [15:0] sample,
                                                  input logic [15:0] gain,
                                                  input logic user);
    longint      prod;
    longint      scaled;
    logic [15:0] data;
    logic        sat;
    prod   = longint'($signed(sample)) * longint'($signed(gain));
    scaled = prod >>> DROP_BITS;
    sat    = 1'b0;
    if (scaled > OUT_MAX) begin
      data = 16'h7fff;
      sat  = 1'b1;
    end else if (scaled < OUT_MIN) begin
      data = 16'h8000;
      sat  = 1'b1;
    end else begin
      data = 16'(scaled);
    end
    return {data, user | sat};
  endfunction

  // holds the beat until accepted and returns DRIVE_DLY after that edge
  task automatic send_beat(input fxp_pkg::sample_t sample, input logic last,
                           input logic user);
    s_data_i  = sample;
    s_last_i  = last;
    s_user_i  = user;
    s_valid_i = 1'b1;
    @(negedge clk);
    while (!s_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic idle_cycles(input int n);
    s_valid_i = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  task automatic wait_drain();
    s_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  // output ready pattern with the mode sampled at the edge
  initial begin : drive_ready
    int mode_now;
    int draw;
    m_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      mode_now = ready_mode;
      draw     = $random(seed);
      #DRIVE_DLY;
      if (mode_now == READY_HIGH) begin
        m_ready_i = 1'b1;
      end else if (mode_now == READY_LOW) begin
        m_ready_i = 1'b0;
      end else begin
        m_ready_i = draw[0];
      end
    end
  end

  always @(negedge clk) begin : record_inputs
    logic [16:0] r;
    if (arst_n_i && s_valid_i && s_ready_o) begin
      r = expected_result(s_data_i, gain_i, s_user_i);
      exp_q.push_back({r[16:1], s_last_i, r[0]});
      cyc_q.push_back(cycle_count);
      in_count++;
    end
  end

  always @(negedge clk) begin : compare_outputs
    logic [17:0] entry;
    int          latency;
    if (arst_n_i && m_valid_o && m_ready_i) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("output beat appeared with no matching input beat");
      end else begin
        entry   = exp_q.pop_front();
        latency = cycle_count - cyc_q.pop_front();
        check_value("m_data_o", {16'h0, m_data_o}, {16'h0, entry[17:2]});
        check_value("m_last_o", {31'h0, m_last_o}, {31'h0, entry[1]});
        check_value("m_user_o", {31'h0, m_user_o}, {31'h0, entry[0]});
        if (check_latency) begin
          check_value("latency", 32'(latency), 32'd2);
        end
        // saturated beats as the DUT delivers them
        if (m_user_o && (m_data_o == 16'h7fff || m_data_o == 16'h8000)) begin
          sat_count++;
        end
        out_count++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_failure("watchdog expired before the tests finished");
  end

  initial begin : run_tests
    fxp_pkg::sample_t sample;
    logic             user;
    int               waited;
    int               sat_before;
    int               accepted;
    int               low_run;
    logic             took;

    gain_i    = '0;
    s_data_i  = '0;
    s_last_i  = 1'b0;
    s_user_i  = 1'b0;
    s_valid_i = 1'b0;
    arst_n_i  = 1'b1;
    #1;
    arst_n_i  = 1'b0;

    // reset holds both handshakes low
    @(negedge clk);
    check_value("m_valid_o", {31'h0, m_valid_o}, 32'h0);
    check_value("s_ready_o", {31'h0, s_ready_o}, 32'h0);
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    arst_n_i = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!s_ready_o && waited < 4) begin
      waited++;
      @(negedge clk);
    end
    if (!s_ready_o) begin
      stop_with_failure("s_ready_o did not rise after reset was released");
    end
    check_value("m_valid_o", {31'h0, m_valid_o}, 32'h0);
    @(posedge clk);
    #DRIVE_DLY;

    // unity gain passes samples through in two cycles
    gain_i = 16'h1000;
    check_latency = 1'b1;
    for (int i = 0; i < UNITY_BEATS; i++) begin
      sample = fxp_pkg::sample_t'($random(seed));
      user   = 1'($random(seed));
      send_beat(sample, i == UNITY_BEATS - 1, user);
    end
    wait_drain();
    check_latency = 1'b0;

    // gain near 8.0 drives most products out of range
    gain_i = 16'h7fff;
    sat_before = sat_count;
    send_beat(16'h7000, 1'b0, 1'b0);
    send_beat(16'h9000, 1'b0, 1'b0);
    send_beat(16'h0100, 1'b0, 1'b0);
    send_beat(16'h0100, 1'b0, 1'b1);
    send_beat(16'h4000, 1'b0, 1'b1);
    send_beat(16'h8000, 1'b1, 1'b0);
    wait_drain();
    check_value("saturated beats", 32'(sat_count - sat_before), 32'd4);

    // half gain on odd samples so negative results floor
    gain_i = 16'h0800;
    send_beat(16'hffff, 1'b0, 1'b0);
    send_beat(16'hff01, 1'b0, 1'b0);
    send_beat(16'h0001, 1'b0, 1'b1);
    send_beat(16'hfe81, 1'b1, 1'b0);
    wait_drain();

    // random gains, samples, gaps and output stalls
    ready_mode = READY_RANDOM;
    for (int blk = 0; blk < RAND_BLOCKS; blk++) begin
      wait_drain();
      gain_i = fxp_pkg::gain_t'($random(seed)) >>> (blk % 4);
      for (int i = 0; i < RAND_PER_BLOCK; i++) begin
        sample = fxp_pkg::sample_t'($random(seed));
        user   = 1'($random(seed));
        send_beat(sample, i == RAND_PER_BLOCK - 1, user);
        idle_cycles({$random(seed)} % 3);
      end
    end
    wait_drain();

    // with the output held off the pipeline takes four beats then closes
    gain_i = 16'h1800;
    ready_mode = READY_LOW;
    idle_cycles(2);
    accepted  = 0;
    low_run   = 0;
    s_data_i  = fxp_pkg::sample_t'($random(seed));
    s_last_i  = 1'b0;
    s_user_i  = 1'b0;
    s_valid_i = 1'b1;
    while (low_run < 3) begin
      @(negedge clk);
      took = s_ready_o;
      @(posedge clk);
      #DRIVE_DLY;
      if (took) begin
        accepted++;
        low_run  = 0;
        s_data_i = fxp_pkg::sample_t'($random(seed));
        s_user_i = 1'($random(seed));
      end else begin
        low_run++;
      end
    end
    check_value("beats taken while stalled", 32'(accepted), 32'd4);
    ready_mode = READY_HIGH;
    send_beat(s_data_i, 1'b0, s_user_i);
    for (int i = accepted + 1; i < BP_BEATS; i++) begin
      sample = fxp_pkg::sample_t'($random(seed));
      user   = 1'($random(seed));
      send_beat(sample, i == BP_BEATS - 1, user);
    end
    wait_drain();

    if (out_count != in_count) begin
      stop_with_failure("number of output beats differs from number of input beats");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule
